/* decode_stage.f */
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/inst_classifier.sv
rtl/imm_gen.sv
rtl/operand_bypass.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
sim/tb_decode_stage.sv

/* rtl/decode_stage.sv */
`timescale 1ns/10ps
`include "rv_decode_cfg.svh"

module decode_stage (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    flush_i,
  input  logic                    inst_valid_i,
  input  logic [`XLEN-1:0]        pc_i,
  input  logic [31:0]             inst_i,
  input  logic [`XLEN-1:0]        rs1_data_i,
  input  logic [`XLEN-1:0]        rs2_data_i,
  input  logic [`XLEN-1:0]        ex_result_i,
  input  logic [`XLEN-1:0]        ex_csr_rdata_i,
  input  logic [`REG_ADDR_W-1:0]  mem_rd_addr_i,
  input  logic [`XLEN-1:0]        mem_rd_data_i,
  output logic                    ready_o,
  output logic [`REG_ADDR_W-1:0]  rs1_idx_o,
  output logic [`REG_ADDR_W-1:0]  rs2_idx_o,
  output logic                    ex_valid_o,
  output logic [`XLEN-1:0]        ex_pc_o,
  output logic [`REG_ADDR_W-1:0]  ex_rd_o,
  output logic [`XLEN-1:0]        ex_rs1_val_o,
  output logic [`XLEN-1:0]        ex_rs2_val_o,
  output logic [`XLEN-1:0]        ex_imm_o,
  output logic [`XLEN-1:0]        ex_csr_imm_o,
  output logic                    ex_csr_imm_valid_o,
  output logic [`CSR_ADDR_W-1:0]  ex_csr_addr_o,
  output rv_decode_pkg::exc_op_e  ex_exc_op_o,
  output rv_decode_pkg::alu_op_e  ex_alu_op_o,
  output rv_decode_pkg::mem_op_e  ex_mem_op_o,
  output rv_decode_pkg::csr_op_e  ex_csr_op_o,
  output logic [`TRAP_W-1:0]      ex_trap_o,
  output logic                    ras_push_valid_o,
  output logic [`XLEN-1:0]        ras_push_addr_o
);
  import rv_decode_pkg::*;

  exc_op_e                exc_op;
  alu_op_e                alu_op;
  mem_op_e                mem_op;
  csr_op_e                csr_op;
  imm_fmt_e               imm_fmt;
  logic                   use_rs1;
  logic                   use_rs2;
  logic                   use_rd;
  logic                   is_call;
  logic [`TRAP_W-1:0]     trap;
  logic [`XLEN-1:0]       imm;
  logic [`XLEN-1:0]       csr_imm;
  logic                   csr_imm_valid;
  logic [`REG_ADDR_W-1:0] rd_idx;
  logic [`CSR_ADDR_W-1:0] csr_addr;
  logic [`XLEN-1:0]       rs1_val;
  logic [`XLEN-1:0]       rs2_val;
  logic                   load_use;
  logic                   load;

  inst_classifier i_inst_classifier (
    .inst_i    (inst_i),
    .exc_op_o  (exc_op),
    .alu_op_o  (alu_op),
    .mem_op_o  (mem_op),
    .csr_op_o  (csr_op),
    .imm_fmt_o (imm_fmt),
    .use_rs1_o (use_rs1),
    .use_rs2_o (use_rs2),
    .use_rd_o  (use_rd),
    .is_call_o (is_call),
    .trap_o    (trap)
  );

  imm_gen i_imm_gen (
    .inst_i          (inst_i),
    .imm_fmt_i       (imm_fmt),
    .imm_o           (imm),
    .csr_imm_o       (csr_imm),
    .csr_imm_valid_o (csr_imm_valid)
  );

  // unused fields read as x0 so they never match a hazard
  assign rs1_idx_o = use_rs1 ? inst_i[19:15] : '0;
  assign rs2_idx_o = use_rs2 ? inst_i[24:20] : '0;
  assign rd_idx    = use_rd ? inst_i[11:7] : '0;
  assign csr_addr  = (exc_op == EXC_CSR) ? inst_i[31:20] : '0;

  operand_bypass i_operand_bypass (
    .rs1_idx_i      (rs1_idx_o),
    .rs2_idx_i      (rs2_idx_o),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .ex_valid_i     (ex_valid_o),
    .ex_rd_i        (ex_rd_o),
    .ex_is_load_i   (ex_exc_op_o == EXC_LOAD),
    .ex_is_csr_i    (ex_exc_op_o == EXC_CSR),
    .ex_result_i    (ex_result_i),
    .ex_csr_rdata_i (ex_csr_rdata_i),
    .mem_rd_addr_i  (mem_rd_addr_i),
    .mem_rd_data_i  (mem_rd_data_i),
    .rs1_val_o      (rs1_val),
    .rs2_val_o      (rs2_val),
    .load_use_o     (load_use)
  );

  // one stall cycle, the bubble moves the load on to mem
  assign ready_o = !load_use;
  assign load    = inst_valid_i && ready_o;

  assign ras_push_valid_o = load && !flush_i && is_call;
  assign ras_push_addr_o  = pc_i + `XLEN'(`LINK_OFFSET);

  id_ex_reg i_id_ex_reg (
    .clk                (clk),
    .rst_i              (rst_i),
    .load_i             (load),
    .flush_i            (flush_i),
    .pc_i               (pc_i),
    .rd_i               (rd_idx),
    .rs1_val_i          (rs1_val),
    .rs2_val_i          (rs2_val),
    .imm_i              (imm),
    .csr_imm_i          (csr_imm),
    .csr_imm_valid_i    (csr_imm_valid),
    .csr_addr_i         (csr_addr),
    .exc_op_i           (exc_op),
    .alu_op_i           (alu_op),
    .mem_op_i           (mem_op),
    .csr_op_i           (csr_op),
    .trap_i             (trap),
    .ex_valid_o         (ex_valid_o),
    .ex_pc_o            (ex_pc_o),
    .ex_rd_o            (ex_rd_o),
    .ex_rs1_val_o       (ex_rs1_val_o),
    .ex_rs2_val_o       (ex_rs2_val_o),
    .ex_imm_o           (ex_imm_o),
    .ex_csr_imm_o       (ex_csr_imm_o),
    .ex_csr_imm_valid_o (ex_csr_imm_valid_o),
    .ex_csr_addr_o      (ex_csr_addr_o),
    .ex_exc_op_o        (ex_exc_op_o),
    .ex_alu_op_o        (ex_alu_op_o),
    .ex_mem_op_o        (ex_mem_op_o),
    .ex_csr_op_o        (ex_csr_op_o),
    .ex_trap_o          (ex_trap_o)
  );

  // a load-use stall never holds fetch for two cycles in a row
  assert property (@(posedge clk) disable iff (rst_i) !ready_o |=> ready_o)
    else $error("decode_stage: load-use stall longer than one cycle");

endmodule

/* rtl/id_ex_reg.sv */
`timescale 1ns/10ps
`include "rv_decode_cfg.svh"

module id_ex_reg (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    load_i,
  input  logic                    flush_i,
  input  logic [`XLEN-1:0]        pc_i,
  input  logic [`REG_ADDR_W-1:0]  rd_i,
  input  logic [`XLEN-1:0]        rs1_val_i,
  input  logic [`XLEN-1:0]        rs2_val_i,
  input  logic [`XLEN-1:0]        imm_i,
  input  logic [`XLEN-1:0]        csr_imm_i,
  input  logic                    csr_imm_valid_i,
  input  logic [`CSR_ADDR_W-1:0]  csr_addr_i,
  input  rv_decode_pkg::exc_op_e  exc_op_i,
  input  rv_decode_pkg::alu_op_e  alu_op_i,
  input  rv_decode_pkg::mem_op_e  mem_op_i,
  input  rv_decode_pkg::csr_op_e  csr_op_i,
  input  logic [`TRAP_W-1:0]      trap_i,
  output logic                    ex_valid_o,
  output logic [`XLEN-1:0]        ex_pc_o,
  output logic [`REG_ADDR_W-1:0]  ex_rd_o,
  output logic [`XLEN-1:0]        ex_rs1_val_o,
  output logic [`XLEN-1:0]        ex_rs2_val_o,
  output logic [`XLEN-1:0]        ex_imm_o,
  output logic [`XLEN-1:0]        ex_csr_imm_o,
  output logic                    ex_csr_imm_valid_o,
  output logic [`CSR_ADDR_W-1:0]  ex_csr_addr_o,
  output rv_decode_pkg::exc_op_e  ex_exc_op_o,
  output rv_decode_pkg::alu_op_e  ex_alu_op_o,
  output rv_decode_pkg::mem_op_e  ex_mem_op_o,
  output rv_decode_pkg::csr_op_e  ex_csr_op_o,
  output logic [`TRAP_W-1:0]      ex_trap_o
);
  import rv_decode_pkg::*;

  logic take;

  assign take = load_i && !flush_i;

  // a bubble clears the control fields
  always_ff @(posedge clk) begin
    if (rst_i || !take) begin
      ex_valid_o         <= 1'b0;
      ex_rd_o            <= '0;
      ex_csr_imm_valid_o <= 1'b0;
      ex_exc_op_o        <= EXC_NONE;
      ex_alu_op_o        <= ALU_ADD;
      ex_mem_op_o        <= MEM_NONE;
      ex_csr_op_o        <= CSR_NONE;
      ex_trap_o          <= '0;
    end else begin
      ex_valid_o         <= 1'b1;
      ex_rd_o            <= rd_i;
      ex_csr_imm_valid_o <= csr_imm_valid_i;
      ex_exc_op_o        <= exc_op_i;
      ex_alu_op_o        <= alu_op_i;
      ex_mem_op_o        <= mem_op_i;
      ex_csr_op_o        <= csr_op_i;
      ex_trap_o          <= trap_i;
    end
  end

  // operand payload
  always_ff @(posedge clk) begin
    if (take) begin
      ex_pc_o       <= pc_i;
      ex_rs1_val_o  <= rs1_val_i;
      ex_rs2_val_o  <= rs2_val_i;
      ex_imm_o      <= imm_i;
      ex_csr_imm_o  <= csr_imm_i;
      ex_csr_addr_o <= csr_addr_i;
    end
  end

  // a bubble held for ex never carries an operation or a trap
  assert property (@(posedge clk) disable iff (rst_i)
    !ex_valid_o |-> ex_trap_o == '0 && ex_exc_op_o == EXC_NONE &&
                    ex_mem_op_o == MEM_NONE && ex_csr_op_o == CSR_NONE)
    else $error("id_ex_reg: bubble carries an operation");

endmodule

/* rtl/imm_gen.sv */
`timescale 1ns/10ps
`include "rv_decode_cfg.svh"

module imm_gen (
  input  logic [31:0]              inst_i,
  input  rv_decode_pkg::imm_fmt_e  imm_fmt_i,
  output logic [`XLEN-1:0]         imm_o,
  output logic [`XLEN-1:0]         csr_imm_o,
  output logic                     csr_imm_valid_o
);
  import rv_decode_pkg::*;

  logic [`XLEN-1:0] imm_itype;
  logic [`XLEN-1:0] imm_stype;
  logic [`XLEN-1:0] imm_btype;
  logic [`XLEN-1:0] imm_utype;
  logic [`XLEN-1:0] imm_jtype;

  // all formats sign extend from inst[31]
  assign imm_itype = {{21{inst_i[31]}}, inst_i[30:20]};
  assign imm_stype = {{21{inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
  assign imm_btype = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_utype = {inst_i[31:12], 12'b0};
  assign imm_jtype = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    case (imm_fmt_i)
      IMM_I:   imm_o = imm_itype;
      IMM_S:   imm_o = imm_stype;
      IMM_B:   imm_o = imm_btype;
      IMM_U:   imm_o = imm_utype;
      IMM_J:   imm_o = imm_jtype;
      default: imm_o = '0;
    endcase
  end

  // csrrwi, csrrsi, csrrci
  assign csr_imm_valid_o = (inst_i[6:0] == OPC_SYSTEM) && inst_i[14] && (inst_i[13:12] != 2'b00);
  assign csr_imm_o = {{(`XLEN-`REG_ADDR_W){1'b0}}, inst_i[19:15]};

endmodule

/* rtl/inst_classifier.sv */
`timescale 1ns/10ps
`include "rv_decode_cfg.svh"

module inst_classifier (
  input  logic [31:0]              inst_i,
  output rv_decode_pkg::exc_op_e   exc_op_o,
  output rv_decode_pkg::alu_op_e   alu_op_o,
  output rv_decode_pkg::mem_op_e   mem_op_o,
  output rv_decode_pkg::csr_op_e   csr_op_o,
  output rv_decode_pkg::imm_fmt_e  imm_fmt_o,
  output logic                     use_rs1_o,
  output logic                     use_rs2_o,
  output logic                     use_rd_o,
  output logic                     is_call_o,
  output logic [`TRAP_W-1:0]       trap_o
);
  import rv_decode_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;
  logic       sys_trap;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  always_comb begin
    exc_op_o  = EXC_NONE;
    alu_op_o  = ALU_ADD;
    mem_op_o  = MEM_NONE;
    csr_op_o  = CSR_NONE;
    imm_fmt_o = IMM_NONE;
    use_rs1_o = 1'b0;
    use_rs2_o = 1'b0;
    use_rd_o  = 1'b0;
    is_call_o = 1'b0;
    trap_o    = '0;
    illegal   = 1'b0;
    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        exc_op_o  = (opcode == OPC_LUI) ? EXC_LUI : EXC_AUIPC;
        imm_fmt_o = IMM_U;
        use_rd_o  = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        exc_op_o  = (opcode == OPC_JAL) ? EXC_JAL : EXC_JALR;
        imm_fmt_o = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        use_rs1_o = (opcode == OPC_JALR);
        use_rd_o  = 1'b1;
        // a call is a jump that links
        is_call_o = (inst_i[11:7] != '0);
        illegal   = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        exc_op_o  = EXC_BRANCH;
        imm_fmt_o = IMM_B;
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
        case (funct3)
          3'b000:  alu_op_o = ALU_BEQ;
          3'b001:  alu_op_o = ALU_BNE;
          3'b100:  alu_op_o = ALU_BLT;
          3'b101:  alu_op_o = ALU_BGE;
          3'b110:  alu_op_o = ALU_BLTU;
          3'b111:  alu_op_o = ALU_BGEU;
          default: illegal  = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        exc_op_o  = EXC_LOAD;
        imm_fmt_o = IMM_I;
        use_rs1_o = 1'b1;
        use_rd_o  = 1'b1;
        case (funct3)
          3'b000:  mem_op_o = MEM_LB;
          3'b001:  mem_op_o = MEM_LH;
          3'b010:  mem_op_o = MEM_LW;
          3'b100:  mem_op_o = MEM_LBU;
          3'b101:  mem_op_o = MEM_LHU;
          default: illegal  = 1'b1;
        endcase
      end
      OPC_STORE: begin
        exc_op_o  = EXC_STORE;
        imm_fmt_o = IMM_S;
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
        case (funct3)
          3'b000:  mem_op_o = MEM_SB;
          3'b001:  mem_op_o = MEM_SH;
          3'b010:  mem_op_o = MEM_SW;
          default: illegal  = 1'b1;
        endcase
      end
      OPC_OPIMM: begin
        exc_op_o  = EXC_OPIMM;
        imm_fmt_o = IMM_I;
        use_rs1_o = 1'b1;
        use_rd_o  = 1'b1;
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b010: alu_op_o = ALU_SLT;
          3'b011: alu_op_o = ALU_SLTU;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          3'b001: begin
            alu_op_o = ALU_SLL;
            illegal  = (funct7 != 7'b0000000);
          end
          default: begin
            // srli or srai, told apart by inst[30]
            alu_op_o = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal  = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPC_OP: begin
        exc_op_o  = EXC_OPREG;
        use_rs1_o = 1'b1;
        use_rs2_o = 1'b1;
        use_rd_o  = 1'b1;
        if (funct7 == 7'b0000001) begin
          // rv32m, funct3 indexes mul..remu directly
          alu_op_o = alu_op_e'(5'(ALU_MUL) + 5'(funct3));
        end else if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  alu_op_o = ALU_ADD;
            3'b001:  alu_op_o = ALU_SLL;
            3'b010:  alu_op_o = ALU_SLT;
            3'b011:  alu_op_o = ALU_SLTU;
            3'b100:  alu_op_o = ALU_XOR;
            3'b101:  alu_op_o = ALU_SRL;
            3'b110:  alu_op_o = ALU_OR;
            default: alu_op_o = ALU_AND;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          alu_op_o = ALU_SUB;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          alu_op_o = ALU_SRA;
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          trap_o[TRAP_ECALL]  = (inst_i == 32'h0000_0073);
          trap_o[TRAP_EBREAK] = (inst_i == 32'h0010_0073);
          trap_o[TRAP_MRET]   = (inst_i == 32'h3020_0073);
          illegal = (trap_o == '0);
        end else if (funct3 == 3'b100) begin
          illegal = 1'b1;
        end else begin
          exc_op_o  = EXC_CSR;
          csr_op_o  = csr_op_e'(funct3[1:0]);
          // immediate forms carry uimm in the rs1 field
          use_rs1_o = !funct3[2];
          use_rd_o  = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      exc_op_o  = EXC_NONE;
      alu_op_o  = ALU_ADD;
      mem_op_o  = MEM_NONE;
      csr_op_o  = CSR_NONE;
      imm_fmt_o = IMM_NONE;
      use_rs1_o = 1'b0;
      use_rs2_o = 1'b0;
      use_rd_o  = 1'b0;
      is_call_o = 1'b0;
      trap_o    = '0;
      trap_o[TRAP_ILLEGAL] = 1'b1;
    end
  end

  assign sys_trap = trap_o[TRAP_ECALL] | trap_o[TRAP_EBREAK] | trap_o[TRAP_MRET];

  // every word is a class, a system trap or illegal, never two at once
  always_comb begin
    assert ($onehot({exc_op_o != EXC_NONE, sys_trap, trap_o[TRAP_ILLEGAL]}))
      else $error("inst_classifier: ambiguous decode of %h", inst_i);
  end

endmodule

/* rtl/operand_bypass.sv */
`timescale 1ns/10ps
`include "rv_decode_cfg.svh"

module operand_bypass (
  input  logic [`REG_ADDR_W-1:0] rs1_idx_i,
  input  logic [`REG_ADDR_W-1:0] rs2_idx_i,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  input  logic                   ex_valid_i,
  input  logic [`REG_ADDR_W-1:0] ex_rd_i,
  input  logic                   ex_is_load_i,
  input  logic                   ex_is_csr_i,
  input  logic [`XLEN-1:0]       ex_result_i,
  input  logic [`XLEN-1:0]       ex_csr_rdata_i,
  input  logic [`REG_ADDR_W-1:0] mem_rd_addr_i,
  input  logic [`XLEN-1:0]       mem_rd_data_i,
  output logic [`XLEN-1:0]       rs1_val_o,
  output logic [`XLEN-1:0]       rs2_val_o,
  output logic                   load_use_o
);

  logic [`XLEN-1:0] ex_fwd_data;
  logic             ex_writes;
  logic             rs1_ex_hit;
  logic             rs2_ex_hit;

  // ex > mem > register file; mem addr zero means no write
  function automatic logic [`XLEN-1:0] pick(
    input logic                   ex_hit,
    input logic [`XLEN-1:0]       ex_data,
    input logic [`REG_ADDR_W-1:0] idx,
    input logic [`REG_ADDR_W-1:0] mem_addr,
    input logic [`XLEN-1:0]       mem_data,
    input logic [`XLEN-1:0]       rf_data
  );
    if (ex_hit) begin
      return ex_data;
    end else if (mem_addr != '0 && idx == mem_addr) begin
      return mem_data;
    end
    return rf_data;
  endfunction

  // a csr instruction writes the old csr value to rd
  assign ex_fwd_data = ex_is_csr_i ? ex_csr_rdata_i : ex_result_i;
  assign ex_writes   = ex_valid_i && (ex_rd_i != '0);
  assign rs1_ex_hit  = ex_writes && (rs1_idx_i == ex_rd_i);
  assign rs2_ex_hit  = ex_writes && (rs2_idx_i == ex_rd_i);

  assign rs1_val_o = pick(rs1_ex_hit, ex_fwd_data, rs1_idx_i, mem_rd_addr_i, mem_rd_data_i,
                          rs1_data_i);
  assign rs2_val_o = pick(rs2_ex_hit, ex_fwd_data, rs2_idx_i, mem_rd_addr_i, mem_rd_data_i,
                          rs2_data_i);

  // load data only exists from mem onward
  assign load_use_o = ex_is_load_i && (rs1_ex_hit || rs2_ex_hit);

endmodule

/* rtl/rv_decode_cfg.svh */
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// data and address width
`define XLEN 32

// register file index width
`define REG_ADDR_W 5

// csr address field, inst[31:20]
`define CSR_ADDR_W 12

// return address distance from the call pc
`define LINK_OFFSET 4

// trap flag vector, one bit per trap_e position
`define TRAP_W 4

`endif

/* rtl/rv_decode_pkg.sv */
package rv_decode_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OPIMM  = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // instruction class carried to ex
  typedef enum logic [3:0] {
    EXC_NONE, EXC_LUI, EXC_AUIPC, EXC_JAL, EXC_JALR, EXC_BRANCH,
    EXC_LOAD, EXC_STORE, EXC_OPIMM, EXC_OPREG, EXC_CSR
  } exc_op_e;

  // mul..remu must stay in funct3 order
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
    ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_op_e;

  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW,
    MEM_SB, MEM_SH, MEM_SW
  } mem_op_e;

  // encoding follows funct3[1:0] of the csr instructions
  typedef enum logic [1:0] {
    CSR_NONE  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
  } imm_fmt_e;

  // bit positions in the trap flag vector
  typedef enum logic [1:0] {
    TRAP_ECALL   = 2'd0,
    TRAP_EBREAK  = 2'd1,
    TRAP_MRET    = 2'd2,
    TRAP_ILLEGAL = 2'd3
  } trap_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# builds the decode stage testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f decode_stage.f \
  --top-module tb_decode_stage \
  -Mdir obj_dir \
  -o sim_decode_stage

./obj_dir/sim_decode_stage

/* sim/tb_decode_stage.sv */
`timescale 1ns/10ps

module tb_decode_stage;
  import rv_decode_pkg::*;

  logic        clk;
  logic        rst_i;
  logic        flush_i;
  logic        inst_valid_i;
  logic [31:0] pc_i;
  logic [31:0] inst_i;
  logic [31:0] rs1_data_i;
  logic [31:0] rs2_data_i;
  logic [31:0] ex_result_i;
  logic [31:0] ex_csr_rdata_i;
  logic [4:0]  mem_rd_addr_i;
  logic [31:0] mem_rd_data_i;
  logic        ready_o;
  logic [4:0]  rs1_idx_o;
  logic [4:0]  rs2_idx_o;
  logic        ex_valid_o;
  logic [31:0] ex_pc_o;
  logic [4:0]  ex_rd_o;
  logic [31:0] ex_rs1_val_o;
  logic [31:0] ex_rs2_val_o;
  logic [31:0] ex_imm_o;
  logic [31:0] ex_csr_imm_o;
  logic        ex_csr_imm_valid_o;
  logic [11:0] ex_csr_addr_o;
  exc_op_e     ex_exc_op_o;
  alu_op_e     ex_alu_op_o;
  mem_op_e     ex_mem_op_o;
  csr_op_e     ex_csr_op_o;
  logic [3:0]  ex_trap_o;
  logic        ras_push_valid_o;
  logic [31:0] ras_push_addr_o;

  // expected decode of the word currently on inst_i
  exc_op_e     nxt_exc;
  alu_op_e     nxt_alu;
  mem_op_e     nxt_mem;
  csr_op_e     nxt_csr;
  logic [3:0]  nxt_trap;
  logic [31:0] nxt_imm;
  logic [4:0]  nxt_rs1;
  logic [4:0]  nxt_rs2;
  logic [4:0]  nxt_rd;
  logic        nxt_call;

  // expected id/ex register contents
  logic        exp_valid;
  exc_op_e     exp_exc;
  alu_op_e     exp_alu;
  mem_op_e     exp_mem;
  csr_op_e     exp_csr;
  logic [3:0]  exp_trap;
  logic [31:0] exp_imm;
  logic [4:0]  exp_rd;
  logic [31:0] exp_pc;
  logic [31:0] exp_rs1;
  logic [31:0] exp_rs2;
  logic [11:0] exp_csr_addr;
  logic [31:0] exp_csr_imm;
  logic        exp_csr_imm_valid;
  logic        exp_stall;
  logic        exp_push;

  logic [4:0]  mem_sel;
  logic        flush_sel;

  decode_stage i_decode_stage (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  // {rs1, rs2, rd} read or written by each class
  function automatic logic [2:0] reg_use(input exc_op_e exc, input logic [31:0] inst);
    case (exc)
      EXC_LUI, EXC_AUIPC, EXC_JAL:   return 3'b001;
      EXC_JALR, EXC_LOAD, EXC_OPIMM: return 3'b101;
      EXC_BRANCH, EXC_STORE:         return 3'b110;
      EXC_OPREG:                     return 3'b111;
      EXC_CSR:                       return inst[14] ? 3'b001 : 3'b101;
      default:                       return 3'b000;
    endcase
  endfunction

  // ex beats mem beats register file and x0 never matches
  function automatic logic [31:0] fwd_value(input logic [4:0] idx, input logic [31:0] rf_data);
    if (exp_valid && exp_rd != 5'd0 && idx == exp_rd) begin
      return (exp_exc == EXC_CSR) ? ex_csr_rdata_i : ex_result_i;
    end
    if (mem_rd_addr_i != 5'd0 && idx == mem_rd_addr_i) begin
      return mem_rd_data_i;
    end
    return rf_data;
  endfunction

  assign exp_stall = exp_valid && exp_exc == EXC_LOAD && exp_rd != 5'd0 &&
                     (nxt_rs1 == exp_rd || nxt_rs2 == exp_rd);
  assign exp_push  = inst_valid_i && !exp_stall && !flush_i && nxt_call;

  // reference id/ex register
  always @(posedge clk) begin
    if (rst_i || !inst_valid_i || exp_stall || flush_i) begin
      exp_valid <= 1'b0;
    end else begin
      exp_valid         <= 1'b1;
      exp_exc           <= nxt_exc;
      exp_alu           <= nxt_alu;
      exp_mem           <= nxt_mem;
      exp_csr           <= nxt_csr;
      exp_trap          <= nxt_trap;
      exp_imm           <= nxt_imm;
      exp_rd            <= nxt_rd;
      exp_pc            <= pc_i;
      exp_rs1           <= fwd_value(nxt_rs1, rs1_data_i);
      exp_rs2           <= fwd_value(nxt_rs2, rs2_data_i);
      exp_csr_addr      <= (nxt_exc == EXC_CSR) ? inst_i[31:20] : 12'h0;
      exp_csr_imm       <= {27'b0, inst_i[19:15]};
      exp_csr_imm_valid <= (nxt_exc == EXC_CSR) && inst_i[14];
    end
  end

  // fresh register file, ex and mem data every cycle
  always @(posedge clk) begin
    rs1_data_i     <= $urandom;
    rs2_data_i     <= $urandom;
    ex_result_i    <= $urandom;
    ex_csr_rdata_i <= $urandom;
    mem_rd_data_i  <= $urandom;
  end

  a_bubble: assert property (@(posedge clk) disable iff (rst_i)
    !exp_valid |-> !ex_valid_o && ex_exc_op_o == EXC_NONE && ex_mem_op_o == MEM_NONE &&
                   ex_csr_op_o == CSR_NONE && ex_trap_o == 4'b0)
    else fail_run($sformatf("CHECK FAILED at %0t: bubble expected, ex_valid_o %0b exc %0d",
                            $time, ex_valid_o, ex_exc_op_o));

  a_ctrl: assert property (@(posedge clk) disable iff (rst_i)
    exp_valid |-> ex_valid_o && ex_exc_op_o == exp_exc && ex_alu_op_o == exp_alu &&
                  ex_mem_op_o == exp_mem && ex_csr_op_o == exp_csr && ex_trap_o == exp_trap &&
                  ex_rd_o == exp_rd)
    else fail_run($sformatf(
      "CHECK FAILED at %0t: exc %0d alu %0d mem %0d trap %b, exp %0d %0d %0d %b",
      $time, ex_exc_op_o, ex_alu_op_o, ex_mem_op_o, ex_trap_o,
      exp_exc, exp_alu, exp_mem, exp_trap));

  a_payload: assert property (@(posedge clk) disable iff (rst_i)
    exp_valid |-> ex_pc_o == exp_pc && ex_imm_o == exp_imm && ex_csr_addr_o == exp_csr_addr &&
                  ex_csr_imm_valid_o == exp_csr_imm_valid &&
                  (!exp_csr_imm_valid || ex_csr_imm_o == exp_csr_imm))
    else fail_run($sformatf("CHECK FAILED at %0t: imm %h expected %h, csr addr %h expected %h",
                            $time, ex_imm_o, exp_imm, ex_csr_addr_o, exp_csr_addr));

  a_operands: assert property (@(posedge clk) disable iff (rst_i)
    exp_valid |-> ex_rs1_val_o == exp_rs1 && ex_rs2_val_o == exp_rs2)
    else fail_run($sformatf("CHECK FAILED at %0t: operands %h %h expected %h %h",
                            $time, ex_rs1_val_o, ex_rs2_val_o, exp_rs1, exp_rs2));

  a_ready: assert property (@(posedge clk) disable iff (rst_i)
    ready_o == !exp_stall && rs1_idx_o == nxt_rs1 && rs2_idx_o == nxt_rs2)
    else fail_run($sformatf("CHECK FAILED at %0t: ready_o %0b idx %0d %0d, expected %0b %0d %0d",
                            $time, ready_o, rs1_idx_o, rs2_idx_o, !exp_stall, nxt_rs1, nxt_rs2));

  a_push: assert property (@(posedge clk) disable iff (rst_i)
    ras_push_valid_o == exp_push && (!exp_push || ras_push_addr_o == pc_i + 32'd4))
    else fail_run($sformatf("CHECK FAILED at %0t: ras push %0b addr %h, expected %0b pc+4 %h",
                            $time, ras_push_valid_o, ras_push_addr_o, exp_push, pc_i + 32'd4));

  // present one word and wait until the stage can take it
  task automatic send(input logic [31:0] inst, input exc_op_e exc, input alu_op_e alu,
                      input mem_op_e mem, input csr_op_e csr, input logic [3:0] trap,
                      input logic [31:0] imm);
    logic [2:0] use_bits;
    int         waited;
    use_bits = reg_use(exc, inst);
    waited   = 0;
    @(posedge clk);
    inst_valid_i  <= 1'b1;
    inst_i        <= inst;
    pc_i          <= $urandom & 32'hFFFF_FFFC;
    flush_i       <= flush_sel;
    mem_rd_addr_i <= mem_sel;
    nxt_exc       <= exc;
    nxt_alu       <= alu;
    nxt_mem       <= mem;
    nxt_csr       <= csr;
    nxt_trap      <= trap;
    nxt_imm       <= imm;
    nxt_rs1       <= use_bits[2] ? inst[19:15] : 5'd0;
    nxt_rs2       <= use_bits[1] ? inst[24:20] : 5'd0;
    nxt_rd        <= use_bits[0] ? inst[11:7] : 5'd0;
    nxt_call      <= (exc == EXC_JAL || exc == EXC_JALR) && inst[11:7] != 5'd0;
    @(negedge clk);
    while (!ready_o) begin
      waited++;
      if (waited > 3) begin
        fail_run("timeout: ready_o stayed low for more than three cycles");
      end else begin
        @(negedge clk);
      end
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      inst_valid_i <= 1'b0;
      flush_i      <= 1'b0;
    end
  endtask

  initial begin
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rd;
    void'($urandom(75642));
    rst_i          = 1'b1;
    flush_i        = 1'b0;
    inst_valid_i   = 1'b0;
    pc_i           = 32'h0;
    inst_i         = 32'h0;
    rs1_data_i     = 32'h0;
    rs2_data_i     = 32'h0;
    ex_result_i    = 32'h0;
    ex_csr_rdata_i = 32'h0;
    mem_rd_addr_i  = 5'd0;
    mem_rd_data_i  = 32'h0;
    nxt_exc        = EXC_NONE;
    nxt_alu        = ALU_ADD;
    nxt_mem        = MEM_NONE;
    nxt_csr        = CSR_NONE;
    nxt_trap       = 4'b0;
    nxt_imm        = 32'h0;
    nxt_rs1        = 5'd0;
    nxt_rs2        = 5'd0;
    nxt_rd         = 5'd0;
    nxt_call       = 1'b0;
    mem_sel        = 5'd0;
    flush_sel      = 1'b0;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
    idle(2);

    // addi, lui, sw, beq, jal, mul
    send(i_type(12'hFFB, 5'd1, 3'b000, 5'd5, 7'h13), EXC_OPIMM, ALU_ADD, MEM_NONE,
         CSR_NONE, 4'b0, 32'hFFFF_FFFB);
    send(u_type(20'hABCDE, 5'd6, 7'h37), EXC_LUI, ALU_ADD, MEM_NONE, CSR_NONE, 4'b0,
         32'hABCD_E000);
    // x6 comes from ex and x5 from mem
    mem_sel = 5'd5;
    send(s_type(12'hFF4, 5'd6, 5'd5, 3'b010), EXC_STORE, ALU_ADD, MEM_SW, CSR_NONE, 4'b0,
         32'hFFFF_FFF4);
    send(b_type(13'h1FF8, 5'd6, 5'd5, 3'b000), EXC_BRANCH, ALU_BEQ, MEM_NONE, CSR_NONE,
         4'b0, 32'hFFFF_FFF8);
    mem_sel = 5'd0;
    send(j_type(21'h000800, 5'd1), EXC_JAL, ALU_ADD, MEM_NONE, CSR_NONE, 4'b0, 32'h800);
    send(r_type(7'h01, 5'd6, 5'd5, 3'b000, 5'd7), EXC_OPREG, ALU_MUL, MEM_NONE, CSR_NONE,
         4'b0, 32'h0);
    // ex match wins over mem match
    mem_sel = 5'd7;
    send(r_type(7'h00, 5'd0, 5'd7, 3'b000, 5'd8), EXC_OPREG, ALU_ADD, MEM_NONE, CSR_NONE,
         4'b0, 32'h0);
    mem_sel = 5'd0;
    send(i_type(12'h001, 5'd0, 3'b000, 5'd0, 7'h13), EXC_OPIMM, ALU_ADD, MEM_NONE,
         CSR_NONE, 4'b0, 32'h1);
    send(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd9), EXC_OPREG, ALU_ADD, MEM_NONE, CSR_NONE,
         4'b0, 32'h0);

    // csr forms with the old csr value forwarded from ex
    send(i_type(12'h300, 5'd5, 3'b010, 5'd10, 7'h73), EXC_CSR, ALU_ADD, MEM_NONE, CSR_SET,
         4'b0, 32'h0);
    send(r_type(7'h20, 5'd0, 5'd10, 3'b000, 5'd11), EXC_OPREG, ALU_SUB, MEM_NONE, CSR_NONE,
         4'b0, 32'h0);
    send(i_type(12'h341, 5'd5, 3'b101, 5'd12, 7'h73), EXC_CSR, ALU_ADD, MEM_NONE,
         CSR_WRITE, 4'b0, 32'h0);
    send(i_type(12'h305, 5'd12, 3'b011, 5'd13, 7'h73), EXC_CSR, ALU_ADD, MEM_NONE,
         CSR_CLEAR, 4'b0, 32'h0);

    // the dependent word stalls once and then takes the load result from mem
    send(i_type(12'h008, 5'd13, 3'b010, 5'd14, 7'h03), EXC_LOAD, ALU_ADD, MEM_LW, CSR_NONE,
         4'b0, 32'h8);
    mem_sel = 5'd14;
    send(r_type(7'h00, 5'd14, 5'd14, 3'b000, 5'd15), EXC_OPREG, ALU_ADD, MEM_NONE,
         CSR_NONE, 4'b0, 32'h0);
    mem_sel = 5'd0;

    // system traps and an undefined word
    send(32'h0000_0073, EXC_NONE, ALU_ADD, MEM_NONE, CSR_NONE, 4'b0001, 32'h0);
    send(32'h0010_0073, EXC_NONE, ALU_ADD, MEM_NONE, CSR_NONE, 4'b0010, 32'h0);
    send(32'h3020_0073, EXC_NONE, ALU_ADD, MEM_NONE, CSR_NONE, 4'b0100, 32'h0);
    send(32'hFFFF_FFFF, EXC_NONE, ALU_ADD, MEM_NONE, CSR_NONE, 4'b1000, 32'h0);

    // return address pushes but none for rd x0 or under flush
    send(i_type(12'h000, 5'd2, 3'b000, 5'd1, 7'h67), EXC_JALR, ALU_ADD, MEM_NONE, CSR_NONE,
         4'b0, 32'h0);
    send(j_type(21'h1FFFFC, 5'd0), EXC_JAL, ALU_ADD, MEM_NONE, CSR_NONE, 4'b0,
         32'hFFFF_FFFC);
    flush_sel = 1'b1;
    send(j_type(21'h000010, 5'd1), EXC_JAL, ALU_ADD, MEM_NONE, CSR_NONE, 4'b0, 32'h10);
    flush_sel = 1'b0;
    idle(2);

    // random mix over x0..x3 to stress forwarding and stalls
    for (int n = 0; n < 40; n++) begin
      ra      = 5'($urandom_range(0, 3));
      rb      = 5'($urandom_range(0, 3));
      rd      = 5'($urandom_range(0, 3));
      mem_sel = 5'($urandom_range(0, 3));
      case ($urandom_range(0, 2))
        0: send(i_type(12'h010, ra, 3'b010, rd, 7'h03), EXC_LOAD, ALU_ADD, MEM_LW,
                CSR_NONE, 4'b0, 32'h10);
        1: send(r_type(7'h00, rb, ra, 3'b000, rd), EXC_OPREG, ALU_ADD, MEM_NONE,
                CSR_NONE, 4'b0, 32'h0);
        default: send(i_type(12'h800, ra, 3'b000, rd, 7'h13), EXC_OPIMM, ALU_ADD,
                      MEM_NONE, CSR_NONE, 4'b0, 32'hFFFF_F800);
      endcase
    end
    idle(3);

    $display("Simulation passed");
    $finish;
  end

endmodule
